/* include/rv_config.svh */
// rv64i core configuration
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and address width
`define RV_XLEN      64
`define RV_ILEN      32           // base isa, no compressed forms

// integer register file
`define RV_NUM_REGS  32
`define RV_REG_AW    5

// first fetch after reset
`define RV_RESET_PC  64'h0

`define RV_NOP       32'h0000_0013  // addi x0, x0, 0

`endif

/* rtl/rv_pkg.sv */
// rv64i core types
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   xlen_t;     // data word, also byte address
    typedef logic [`RV_ILEN-1:0]   instr_t;
    typedef logic [`RV_REG_AW-1:0] reg_idx_t;

    // major opcodes this core executes
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_or,
        alu_and, alu_sll, alu_srl, alu_sra,
        alu_pass_b                              // lui, immediate straight through
    } alu_op_e;

    // values are the funct3 codes of the branch group
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } branch_cond_e;

    typedef struct packed {
        opcode_e      opcode;
        reg_idx_t     rd;
        reg_idx_t     rs1;
        reg_idx_t     rs2;
        xlen_t        imm;       // already sign extended
        alu_op_e      alu_op;
        logic         use_imm;   // operand b is imm, not rs2
        branch_cond_e br_cond;
    } decoded_t;

    typedef struct packed {
        logic  taken;
        xlen_t target;
        xlen_t link;             // pc + 4 for jal / jalr
    } branch_res_t;

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        xlen_t    data;
    } wb_t;

    typedef struct packed {
        logic  we;
        xlen_t addr;
        xlen_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
    } redirect_t;

endpackage

/* rtl/rv_fetch.sv */
// instruction fetch stage
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_fetch (
    input  logic              clk_1hz,
    input  logic              reset_n,
    input  rv_pkg::redirect_t redirect,
    input  rv_pkg::instr_t    imem_data,
    output rv_pkg::xlen_t     imem_addr,
    output rv_pkg::instr_t    ir,
    output rv_pkg::xlen_t     ir_pc,
    output logic              ir_valid
);

    rv_pkg::xlen_t pc;

    assign imem_addr = pc;  // rom answers in the same cycle

    // pc, instruction register and slot valid
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc       <= `RV_RESET_PC;
            ir       <= `RV_NOP;
            ir_valid <= 1'b0;        // nothing executes until the first fetch lands
        end else begin
            ir <= imem_data;
            if (redirect.valid) begin
                pc       <= redirect.pc;
                ir_valid <= 1'b0;    // kill the word fetched behind the jump
            end else begin
                pc       <= pc + rv_pkg::xlen_t'(4);
                ir_valid <= 1'b1;
            end
        end
    end

    // address travelling with ir
    always_ff @(posedge clk_1hz) begin
        ir_pc <= pc;
    end

endmodule

/* rtl/rv_decode.sv */
// instruction decoder
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_decode (
    input  rv_pkg::instr_t   ir,
    output rv_pkg::decoded_t dec
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            is_op;
    rv_pkg::xlen_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::alu_op_e arith_op;     // shared by op and op-imm
    logic            arith_legal;
    logic            legal;

    assign opcode = rv_pkg::opcode_e'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];
    assign is_op  = (opcode == rv_pkg::opc_op);

    // immediate formats, all sign extended from ir[31]
    assign imm_i = {{(`RV_XLEN-12){ir[31]}}, ir[31:20]};
    assign imm_s = {{(`RV_XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{(`RV_XLEN-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){ir[31]}}, ir[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    // funct3 / funct7 to alu operation
    always_comb begin
        arith_legal = 1'b1;
        case (funct3)
            3'b000:  arith_op = (is_op && funct7[5]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  arith_op = rv_pkg::alu_sll;
            3'b010:  arith_op = rv_pkg::alu_slt;
            3'b011:  arith_op = rv_pkg::alu_sltu;
            3'b100:  arith_op = rv_pkg::alu_xor;
            3'b101:  arith_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  arith_op = rv_pkg::alu_or;
            default: arith_op = rv_pkg::alu_and;
        endcase
        if (is_op) begin
            arith_legal = (funct7 == 7'b0000000) ||
                          (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        end else if (funct3 == 3'b001) begin
            arith_legal = (ir[31:26] == 6'b000000);     // slli, bit 25 is shamt[5]
        end else if (funct3 == 3'b101) begin
            arith_legal = (ir[31:26] == 6'b000000) || (ir[31:26] == 6'b010000);
        end
    end

    always_comb begin
        dec.opcode  = opcode;
        dec.rd      = ir[11:7];
        dec.rs1     = ir[19:15];
        dec.rs2     = ir[24:20];
        dec.imm     = imm_i;                 // i-type unless overridden
        dec.alu_op  = rv_pkg::alu_add;       // addresses and auipc add
        dec.use_imm = 1'b1;
        dec.br_cond = rv_pkg::branch_cond_e'(funct3);
        legal       = 1'b1;
        case (opcode)
            rv_pkg::opc_lui: begin
                dec.imm    = imm_u;
                dec.alu_op = rv_pkg::alu_pass_b;
            end
            rv_pkg::opc_auipc:  dec.imm = imm_u;
            rv_pkg::opc_op_imm: begin
                dec.alu_op = arith_op;
                legal      = arith_legal;
            end
            rv_pkg::opc_op: begin
                dec.alu_op  = arith_op;
                dec.use_imm = 1'b0;
                legal       = arith_legal;
            end
            rv_pkg::opc_load:   legal = (funct3 == 3'b011);    // ld only
            rv_pkg::opc_store: begin
                dec.imm = imm_s;
                legal   = (funct3 == 3'b011);                 // sd only
            end
            rv_pkg::opc_branch: begin
                dec.imm = imm_b;
                legal   = (funct3[2:1] != 2'b01);             // 010, 011 unused
            end
            rv_pkg::opc_jal:    dec.imm = imm_j;
            rv_pkg::opc_jalr:   legal = (funct3 == 3'b000);
            default:            legal = 1'b0;
        endcase
        // anything unsupported turns into addi x0, no write, store or jump
        if (!legal) begin
            dec.opcode = rv_pkg::opc_op_imm;
            dec.rd     = '0;
        end
    end

endmodule

/* rtl/rv_regfile.sv */
// integer register file
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_regfile (
    input  logic             clk_1hz,
    input  logic             reset_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::wb_t      wb,
    output rv_pkg::xlen_t    rs1_data,
    output rv_pkg::xlen_t    rs2_data
);

    rv_pkg::xlen_t regs [`RV_NUM_REGS];

    // write at the edge, so the next instruction sees the result
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.idx != '0) begin   // x0 never written
            regs[wb.idx] <= wb.data;
        end
    end

    // asynchronous reads, x0 hard zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rtl/rv_alu.sv */
// integer alu
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::xlen_t    ir_pc,
    input  rv_pkg::xlen_t    rs1_data,
    input  rv_pkg::xlen_t    rs2_data,
    output rv_pkg::xlen_t    alu_result
);

    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    logic [5:0]    shamt;

    // auipc adds to its own pc, everything else starts from rs1
    assign op_a  = (dec.opcode == rv_pkg::opc_auipc) ? ir_pc : rs1_data;
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[5:0];  // rv64 uses six shift bits, imm or register alike

    always_comb begin
        case (dec.alu_op)
            rv_pkg::alu_add:    alu_result = op_a + op_b;   // also ld / sd address
            rv_pkg::alu_sub:    alu_result = op_a - op_b;
            rv_pkg::alu_slt:    alu_result = rv_pkg::xlen_t'($signed(op_a) < $signed(op_b));
            rv_pkg::alu_sltu:   alu_result = rv_pkg::xlen_t'(op_a < op_b);
            rv_pkg::alu_xor:    alu_result = op_a ^ op_b;
            rv_pkg::alu_or:     alu_result = op_a | op_b;
            rv_pkg::alu_and:    alu_result = op_a & op_b;
            rv_pkg::alu_sll:    alu_result = op_a << shamt;
            rv_pkg::alu_srl:    alu_result = op_a >> shamt;
            rv_pkg::alu_sra:    alu_result = rv_pkg::xlen_t'($signed(op_a) >>> shamt);
            rv_pkg::alu_pass_b: alu_result = op_b;          // lui
            default:            alu_result = op_a + op_b;
        endcase
    end

endmodule

/* rtl/rv_branch_unit.sv */
// branch and jump unit
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_branch_unit (
    input  rv_pkg::decoded_t    dec,
    input  rv_pkg::xlen_t       ir_pc,
    input  rv_pkg::xlen_t       rs1_data,
    input  rv_pkg::xlen_t       rs2_data,
    output rv_pkg::branch_res_t br
);

    logic          eq, lt, ltu;
    logic          cond_met;
    rv_pkg::xlen_t jalr_sum;

    assign eq       = (rs1_data == rs2_data);
    assign lt       = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu      = (rs1_data < rs2_data);
    assign jalr_sum = rs1_data + dec.imm;

    always_comb begin
        case (dec.br_cond)
            rv_pkg::br_eq:  cond_met = eq;
            rv_pkg::br_ne:  cond_met = !eq;
            rv_pkg::br_lt:  cond_met = lt;
            rv_pkg::br_ge:  cond_met = !lt;
            rv_pkg::br_ltu: cond_met = ltu;
            rv_pkg::br_geu: cond_met = !ltu;
            default:        cond_met = 1'b0;
        endcase
    end

    always_comb begin
        br.link   = ir_pc + rv_pkg::xlen_t'(4);
        br.target = ir_pc + dec.imm;        // pc relative for branches and jal
        br.taken  = 1'b0;
        case (dec.opcode)
            rv_pkg::opc_branch: br.taken = cond_met;
            rv_pkg::opc_jal:    br.taken = 1'b1;
            rv_pkg::opc_jalr: begin
                br.taken  = 1'b1;
                br.target = {jalr_sum[`RV_XLEN-1:1], 1'b0};   // lsb dropped
            end
            default: ;
        endcase
    end

endmodule

/* rtl/rv_commit.sv */
// write-back, store and redirect
`timescale 1ns/1ps

module rv_commit (
    input  rv_pkg::decoded_t    dec,
    input  logic                ir_valid,
    input  rv_pkg::xlen_t       alu_result,
    input  rv_pkg::branch_res_t br,
    input  rv_pkg::xlen_t       rs2_data,
    input  rv_pkg::xlen_t       dmem_rdata,
    output rv_pkg::wb_t         wb,
    output rv_pkg::dmem_req_t   dmem,
    output rv_pkg::redirect_t   redirect
);

    // write-back source by opcode
    always_comb begin
        wb.idx  = dec.rd;
        wb.data = alu_result;
        wb.en   = 1'b0;
        case (dec.opcode)
            rv_pkg::opc_lui,
            rv_pkg::opc_auipc,
            rv_pkg::opc_op_imm,
            rv_pkg::opc_op:   wb.en = ir_valid;
            rv_pkg::opc_load: begin
                wb.en   = ir_valid;
                wb.data = dmem_rdata;       // doubleword, no extension needed
            end
            rv_pkg::opc_jal,
            rv_pkg::opc_jalr: begin
                wb.en   = ir_valid;
                wb.data = br.link;
            end
            default: ;                      // store and branch write nothing
        endcase
    end

    // one address path for ld and sd
    assign dmem.we    = ir_valid && (dec.opcode == rv_pkg::opc_store);
    assign dmem.addr  = alu_result;
    assign dmem.wdata = rs2_data;

    // squashed slot must not jump either
    assign redirect.valid = ir_valid && br.taken;
    assign redirect.pc    = br.target;

endmodule

/* rtl/rv_core.sv */
// two-stage rv64i core
`timescale 1ns/1ps

module rv_core (
    input  logic              clk_1hz,
    input  logic              reset_n,
    output rv_pkg::xlen_t     imem_addr,
    input  rv_pkg::instr_t    imem_data,
    output rv_pkg::dmem_req_t dmem,
    input  rv_pkg::xlen_t     dmem_rdata
);

    rv_pkg::instr_t      ir;
    rv_pkg::xlen_t       ir_pc;
    logic                ir_valid;
    rv_pkg::decoded_t    dec;
    rv_pkg::xlen_t       rs1_data;
    rv_pkg::xlen_t       rs2_data;
    rv_pkg::xlen_t       alu_result;
    rv_pkg::branch_res_t br;
    rv_pkg::wb_t         wb;
    rv_pkg::redirect_t   redirect;

    // stage 1
    rv_fetch u_fetch (
        .clk_1hz   (clk_1hz),
        .reset_n   (reset_n),
        .redirect  (redirect),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .ir        (ir),
        .ir_pc     (ir_pc),
        .ir_valid  (ir_valid)
    );

    // stage 2, all combinational up to the register file write
    rv_decode u_decode (
        .ir  (ir),
        .dec (dec)
    );

    rv_regfile u_regfile (
        .clk_1hz  (clk_1hz),
        .reset_n  (reset_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .dec        (dec),
        .ir_pc      (ir_pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result)
    );

    rv_branch_unit u_branch (
        .dec      (dec),
        .ir_pc    (ir_pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .br       (br)
    );

    rv_commit u_commit (
        .dec        (dec),
        .ir_valid   (ir_valid),
        .alu_result (alu_result),
        .br         (br),
        .rs2_data   (rs2_data),
        .dmem_rdata (dmem_rdata),
        .wb         (wb),
        .dmem       (dmem),
        .redirect   (redirect)
    );

endmodule

/* dv/rv_core_sva.sv */
// core interface assertions
`timescale 1ns/1ps

module rv_core_sva (
    input logic              clk_1hz,
    input logic              reset_n,
    input rv_pkg::xlen_t     imem_addr,
    input rv_pkg::dmem_req_t dmem
);

    // no store may leave the core while it is held in reset
    assert property (@(posedge clk_1hz) !reset_n |-> !dmem.we)
        else $error("store issued during reset");

    // fetch address is always on an instruction boundary
    assert property (@(posedge clk_1hz) disable iff (!reset_n) imem_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    assert property (@(posedge clk_1hz) disable iff (!reset_n)
        dmem.we |-> dmem.addr[2:0] == 3'b000)   // sd only, doubleword
        else $error("store address not doubleword aligned");

endmodule

bind rv_core rv_core_sva u_sva (.*);

/* dv/rv_core_tb.sv */
// rv64i core testbench
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_tb;

    // each test runs at most 64 words twice plus reset and drain
    localparam int max_cycles = 5 * (12 + 2 * 64 + 12) + 100;

    logic              clk_1hz = 1'b0;
    logic              reset_n = 1'b0;
    rv_pkg::xlen_t     imem_addr;
    rv_pkg::instr_t    imem_data;
    rv_pkg::dmem_req_t dmem;
    rv_pkg::xlen_t     dmem_rdata;

    logic [31:0] rom [64];
    logic [63:0] ram [64];
    logic [31:0] lcg_state = 32'hb5a4_b538;
    int          cycles = 0;
    int          store_count = 0;
    int          n_ins, test_errs, n_pass, n_fail, br_k;
    int          exp_slot [$];
    logic [63:0] exp_val [$];
    logic [63:0] rv [4];          // reference values of x0..x3 in the branch test

    rv_core u_dut (.*);

    always #4 clk_1hz = ~clk_1hz;   // 8 ns period

    // memory models read asynchronously
    // a misaligned fetch reads zero and never reaches the intended word
    assign imem_data  = (imem_addr[1:0] == 2'b00) ? rom[imem_addr[7:2]] : 32'h0;
    assign dmem_rdata = ram[dmem.addr[8:3]];

    always @(posedge clk_1hz) begin
        cycles <= cycles + 1;
        if (dmem.we) begin
            ram[dmem.addr[8:3]] <= dmem.wdata;
            store_count <= store_count + 1;
        end
        if (cycles > max_cycles) begin
            $display("run stopped after %0d cycles without finishing", max_cycles);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [63:0] fill_word(input int i);
        return {32'hc0de_f00d, 26'h0, 6'(i)};   // marks untouched ram per slot
    endfunction

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};   // sd
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic cond_holds(input logic [2:0] f3, input logic [63:0] a,
                                        input logic [63:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] ins);
        rom[n_ins] = ins;
        n_ins++;
    endtask

    task automatic expect_slot(input int slot, input logic [63:0] v);
        exp_slot.push_back(slot);
        exp_val.push_back(v);
    endtask

    // x3 holds the result, stored to the next free slot
    task automatic store_x3(input logic [63:0] v);
        expect_slot(exp_slot.size(), v);
        emit(s_type(12'(exp_slot.size() * 8 - 8), 5'd3, 5'd0));
    endtask

    task automatic begin_test();
        @(posedge clk_1hz);
        reset_n <= 1'b0;
        n_ins = 0;
        exp_slot.delete();
        exp_val.delete();
        for (int i = 0; i < 64; i++) begin
            rom[i] = `RV_NOP;
            ram[i] <= fill_word(i);
        end
    endtask

    // park the core, release reset and let the program run out
    task automatic run_program();
        emit(j_type(21'd0, 5'd0));             // jal x0, 0 parks the core
        repeat (10) @(posedge clk_1hz);
        reset_n <= 1'b1;
        repeat (2 * n_ins + 10) @(posedge clk_1hz);
        @(negedge clk_1hz);
    endtask

    task automatic check_ram(input string name);
        foreach (exp_slot[i]) begin
            assert (ram[exp_slot[i]] == exp_val[i])
                else begin
                    $display("FAILED %s slot %0d expected %h actual %h",
                             name, exp_slot[i], exp_val[i], ram[exp_slot[i]]);
                    test_errs++;
                end
        end
    endtask

    task automatic report_result(input string name);
        if (test_errs == 0) begin
            n_pass++;
            $display("%s: ok", name);
        end else begin
            n_fail++;
            $display("%s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic finish_test(input string name);
        run_program();
        check_ram(name);
        report_result(name);
    endtask

    task automatic reset_idle();
        int stores;
        begin_test();
        @(negedge clk_1hz);
        assert (imem_addr == `RV_RESET_PC)
            else begin
                $display("FAILED reset_idle expected %h actual %h", `RV_RESET_PC, imem_addr);
                test_errs++;
            end
        for (int i = 0; i < 8; i++) begin
            emit(`RV_NOP);
        end
        stores = store_count;
        run_program();
        assert (store_count == stores)
            else begin
                $display("reset_idle: a store happened while running only no-ops");
                test_errs++;
            end
        report_result("reset_idle");
    endtask

    task automatic alu_ops();
        logic [11:0] ia, ib, ic;
        logic [63:0] a, b, c, p;
        begin_test();
        ia = 12'(lcg_next());
        ib = 12'(lcg_next());
        ic = 12'(lcg_next());
        a  = sext12(ia);
        b  = sext12(ib);
        c  = sext12(ic);
        emit(i_type(ia, 5'd0, 3'd0, 5'd1, 7'b0010011));   // addi x1
        emit(i_type(ib, 5'd0, 3'd0, 5'd2, 7'b0010011));   // addi x2
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        store_x3(a + b);
        emit(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
        store_x3(a - b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd3));
        store_x3({63'b0, $signed(a) < $signed(b)});
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd3));
        store_x3({63'b0, a < b});
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd3));
        store_x3(a ^ b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd3));
        store_x3(a | b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd3));
        store_x3(a & b);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd1, 5'd3));
        store_x3(a << b[5:0]);
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd5, 5'd3));
        store_x3(a >> b[5:0]);
        emit(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
        store_x3($signed(a) >>> b[5:0]);
        emit(i_type(ic, 5'd1, 3'd0, 5'd3, 7'b0010011));
        store_x3(a + c);
        emit(i_type(ic, 5'd1, 3'd2, 5'd3, 7'b0010011));
        store_x3({63'b0, $signed(a) < $signed(c)});
        emit(i_type(ic, 5'd1, 3'd3, 5'd3, 7'b0010011));
        store_x3({63'b0, a < c});
        emit(i_type(ic, 5'd1, 3'd4, 5'd3, 7'b0010011));
        store_x3(a ^ c);
        emit(i_type(ic, 5'd1, 3'd6, 5'd3, 7'b0010011));
        store_x3(a | c);
        emit(i_type(ic, 5'd1, 3'd7, 5'd3, 7'b0010011));
        store_x3(a & c);
        emit(i_type(12'd13, 5'd1, 3'd1, 5'd3, 7'b0010011));
        store_x3(a << 13);
        emit(i_type(12'd7, 5'd1, 3'd5, 5'd3, 7'b0010011));
        store_x3(a >> 7);
        emit(i_type(12'h425, 5'd1, 3'd5, 5'd3, 7'b0010011));
        store_x3($signed(a) >>> 37);
        emit({20'h80001, 5'd3, 7'b0110111});            // lui
        store_x3(64'hffff_ffff_8000_1000);
        p = 64'(n_ins * 4);
        emit({20'h00012, 5'd3, 7'b0010111});            // auipc
        store_x3(p + 64'h12000);
        finish_test("alu_ops");
    endtask

    task automatic load_store();
        begin_test();
        ram[40] <= 64'h0123_4567_89ab_cdef;
        ram[41] <= 64'h1111_0000_2222_0000;
        emit(i_type(12'd320, 5'd0, 3'd3, 5'd1, 7'b0000011));    // ld x1, 320(x0)
        emit(i_type(12'd328, 5'd0, 3'd3, 5'd2, 7'b0000011));
        emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        store_x3(64'h1234_4567_abcd_cdef);
        emit(s_type(12'd8, 5'd1, 5'd0));
        expect_slot(1, 64'h0123_4567_89ab_cdef);
        emit(i_type(12'd123, 5'd1, 3'd0, 5'd0, 7'b0010011));   // addi x0, x1, 123
        emit(s_type(12'd16, 5'd0, 5'd0));
        expect_slot(2, 64'h0);
        expect_slot(40, 64'h0123_4567_89ab_cdef);
        finish_test("load_store");
    endtask

    task automatic br_case(input logic [2:0] f3, input logic [4:0] r1, input logic [4:0] r2);
        emit(b_type(13'd8, r2, r1, f3));
        emit(s_type(12'(br_k * 8), 5'd10, 5'd0));          // fall-through marker
        emit(s_type(12'(256 + br_k * 8), 5'd11, 5'd0));    // target-side marker
        expect_slot(br_k, cond_holds(f3, rv[r1[1:0]], rv[r2[1:0]]) ? fill_word(br_k) : 64'h0f0);
        expect_slot(32 + br_k, 64'h0e1);
        br_k++;
    endtask

    task automatic branches();
        begin_test();
        br_k = 0;
        rv[0] = 64'h0;
        rv[1] = sext12(12'hffb);   // -5
        rv[2] = 64'd3;
        rv[3] = 64'd3;
        emit(i_type(12'hffb, 5'd0, 3'd0, 5'd1, 7'b0010011));
        emit(i_type(12'd3, 5'd0, 3'd0, 5'd2, 7'b0010011));
        emit(i_type(12'd3, 5'd0, 3'd0, 5'd3, 7'b0010011));
        emit(i_type(12'h0f0, 5'd0, 3'd0, 5'd10, 7'b0010011));
        emit(i_type(12'h0e1, 5'd0, 3'd0, 5'd11, 7'b0010011));
        br_case(3'd0, 5'd2, 5'd3);     // beq
        br_case(3'd0, 5'd1, 5'd2);
        br_case(3'd1, 5'd1, 5'd2);     // bne
        br_case(3'd1, 5'd2, 5'd3);
        br_case(3'd4, 5'd1, 5'd2);     // blt
        br_case(3'd4, 5'd2, 5'd1);
        br_case(3'd5, 5'd2, 5'd1);     // bge
        br_case(3'd5, 5'd1, 5'd2);
        br_case(3'd6, 5'd2, 5'd1);     // bltu sees -5 as huge
        br_case(3'd6, 5'd1, 5'd2);
        br_case(3'd7, 5'd1, 5'd2);     // bgeu
        br_case(3'd7, 5'd2, 5'd1);
        finish_test("branches");
    endtask

    task automatic jumps();
        logic [63:0] p1, p2, t;
        begin_test();
        emit(i_type(12'd77, 5'd0, 3'd0, 5'd10, 7'b0010011));
        p1 = 64'(n_ins * 4);
        emit(j_type(21'd8, 5'd1));                    // jal x1, +8
        emit(s_type(12'd0, 5'd10, 5'd0));             // skipped
        emit(s_type(12'd8, 5'd1, 5'd0));
        t = 64'(n_ins * 4 + 12);                      // word after the skipped store
        emit(i_type(12'(t), 5'd0, 3'd0, 5'd5, 7'b0010011));
        p2 = 64'(n_ins * 4);
        emit(i_type(12'd1, 5'd5, 3'd0, 5'd2, 7'b1100111));   // jalr x2, 1(x5) with odd sum
        emit(s_type(12'd16, 5'd10, 5'd0));            // skipped
        emit(s_type(12'd24, 5'd2, 5'd0));
        expect_slot(0, fill_word(0));
        expect_slot(1, p1 + 64'd4);
        expect_slot(2, fill_word(2));
        expect_slot(3, p2 + 64'd4);
        finish_test("jumps");
    endtask

    initial begin
        test_errs = 0;
        n_pass    = 0;
        n_fail    = 0;
        reset_idle();
        alu_ops();
        load_store();
        branches();
        jumps();
        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_branch_unit.sv
rtl/rv_commit.sv
rtl/rv_core.sv
dv/rv_core_sva.sv
dv/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

( verilator --binary --timing --assert --top-module rv_core_tb -f sim.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim ) > sim.log 2>&1
cat sim.log

! grep -q "Regression failed" sim.log && grep -q "Regression passed" sim.log \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL, see sim.log"; exit 1; }
